// File: armCtrlPkg.sv
package armCtrlPkg;

  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] op;
    logic       immFlag;   // Operand 2 is an immediate
    logic [3:0] cmd;
    logic       setFlags;  // S bit
    logic [3:0] rn;
    logic [3:0] rd;
  } dpFieldsT;

  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] op;
    logic       immFlag;   // Offset is a register when set
    logic       preIdx;
    logic       up;
    logic       byteAcc;
    logic       writeBack;
    logic       load;      // LDR when set, STR otherwise
    logic [3:0] rn;
    logic [3:0] rd;
  } memFieldsT;

  // Instruction bits 31 to 12
  typedef union packed {
    dpFieldsT  dp;
    memFieldsT mem;
  } instrHiT;

  localparam logic [1:0] OP_DP  = 2'b00;
  localparam logic [1:0] OP_MEM = 2'b01;
  localparam logic [1:0] OP_BR  = 2'b10;

  localparam logic [3:0] CMD_SUB = 4'b0010;
  localparam logic [3:0] CMD_RSB = 4'b0011;
  localparam logic [3:0] CMD_ADD = 4'b0100;
  localparam logic [3:0] CMD_ADC = 4'b0101;
  localparam logic [3:0] CMD_SBC = 4'b0110;
  localparam logic [3:0] CMD_RSC = 4'b0111;
  localparam logic [3:0] CMD_CMP = 4'b1010;
  localparam logic [3:0] CMD_CMN = 4'b1011;

  localparam logic [3:0] COND_EQ = 4'b0000;
  localparam logic [3:0] COND_NE = 4'b0001;
  localparam logic [3:0] COND_CS = 4'b0010;
  localparam logic [3:0] COND_CC = 4'b0011;
  localparam logic [3:0] COND_MI = 4'b0100;
  localparam logic [3:0] COND_PL = 4'b0101;
  localparam logic [3:0] COND_VS = 4'b0110;
  localparam logic [3:0] COND_VC = 4'b0111;
  localparam logic [3:0] COND_HI = 4'b1000;
  localparam logic [3:0] COND_LS = 4'b1001;
  localparam logic [3:0] COND_GE = 4'b1010;
  localparam logic [3:0] COND_LT = 4'b1011;
  localparam logic [3:0] COND_GT = 4'b1100;
  localparam logic [3:0] COND_LE = 4'b1101;
  localparam logic [3:0] COND_AL = 4'b1110;

  localparam logic [1:0] FWD_NONE = 2'b00;
  localparam logic [1:0] FWD_W    = 2'b01;  // From Writeback result
  localparam logic [1:0] FWD_M    = 2'b10;  // From Memory stage ALU result

  localparam logic [3:0] PC_REG = 4'd15;

endpackage

// File: ctrlDecoder.sv
`timescale 1ns/100ps

module ctrlDecoder import armCtrlPkg::*; (
  input  instrHiT    instrD,
  input  logic       shiftRegD,
  output logic [1:0] regSrcD,
  output logic [1:0] immSrcD,
  output logic       aluSrcD,
  output logic       memtoRegD,
  output logic       regWriteD,
  output logic       memWriteD,
  output logic       branchD,
  output logic [3:0] aluControlD,
  output logic [1:0] flagWriteD,
  output logic       pcSrcD,
  output logic       rSelD,
  output logic       rsrSelD
);

  logic [9:0] controlsD;
  logic       aluOpD;
  logic       isArithD;
  logic       regDpD;

  // Main decoder by op class
  always_comb begin
    case (instrD.dp.op)
      OP_DP: begin
        if (instrD.dp.immFlag) begin
          controlsD = 10'b00_00_101001;  // DP immediate
        end else begin
          controlsD = 10'b00_00_001001;  // DP register
        end
      end
      OP_MEM: begin
        if (instrD.mem.load) begin
          controlsD = 10'b00_01_111000;  // LDR
        end else begin
          controlsD = 10'b10_01_100100;  // STR
        end
      end
      OP_BR:   controlsD = 10'b01_10_100010;  // B
      default: controlsD = 10'b00_00_000000;
    endcase
  end

  assign {regSrcD, immSrcD, aluSrcD, memtoRegD,
          regWriteD, memWriteD, branchD, aluOpD} = controlsD;

  // Commands that produce a carry and overflow
  always_comb begin
    case (instrD.dp.cmd)
      CMD_ADD, CMD_SUB, CMD_RSB, CMD_ADC,
      CMD_SBC, CMD_RSC, CMD_CMP, CMD_CMN: isArithD = 1'b1;
      default:                            isArithD = 1'b0;
    endcase
  end

  // ALU decoder
  always_comb begin
    if (aluOpD) begin
      aluControlD = instrD.dp.cmd;
      flagWriteD  = {instrD.dp.setFlags, instrD.dp.setFlags & isArithD};  // NZ, CV
    end else begin
      aluControlD = CMD_ADD;  // Address and branch target add
      flagWriteD  = 2'b00;
    end
  end

  assign pcSrcD  = ((instrD.dp.rd == PC_REG) & regWriteD) | branchD;

  assign regDpD  = (instrD.dp.op == OP_DP) & ~instrD.dp.immFlag;
  assign rSelD   = regDpD & ~shiftRegD;  // Shift by immediate amount
  assign rsrSelD = regDpD & shiftRegD;   // Shift by register amount

endmodule

// File: condUnit.sv
`timescale 1ns/100ps

module condUnit import armCtrlPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       stallE,
  input  logic [3:0] condE,
  input  logic [3:0] aluFlagsE,
  input  logic [1:0] flagWriteE,
  output logic       condEx,
  output logic [1:0] prevCV
);

  logic [3:0] flags;      // NZCV
  logic [3:0] flagsNext;
  logic       neg, zero, carry, overflow;
  logic       ge;

  assign {neg, zero, carry, overflow} = flags;
  assign ge = (neg == overflow);

  always_comb begin
    case (condE)
      COND_EQ: condEx = zero;
      COND_NE: condEx = ~zero;
      COND_CS: condEx = carry;
      COND_CC: condEx = ~carry;
      COND_MI: condEx = neg;
      COND_PL: condEx = ~neg;
      COND_VS: condEx = overflow;
      COND_VC: condEx = ~overflow;
      COND_HI: condEx = carry & ~zero;
      COND_LS: condEx = ~carry | zero;
      COND_GE: condEx = ge;
      COND_LT: condEx = ~ge;
      COND_GT: condEx = ~zero & ge;
      COND_LE: condEx = zero | ~ge;
      COND_AL: condEx = 1'b1;
      default: condEx = 1'b0;  // 1111 never executes
    endcase
  end

  assign flagsNext[3:2] = (flagWriteE[1] & condEx) ? aluFlagsE[3:2] : flags[3:2];
  assign flagsNext[1:0] = (flagWriteE[0] & condEx) ? aluFlagsE[1:0] : flags[1:0];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= 4'b0000;
    end else if (!stallE) begin
      flags <= flagsNext;
    end
  end

  assign prevCV = flags[1:0];  // Carry in for ADC, SBC, RSC

endmodule

// File: ctrlPipe.sv
`timescale 1ns/100ps

module ctrlPipe import armCtrlPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       stallE,
  input  logic       stallM,
  input  logic       stallW,
  input  logic       flushE,
  input  logic       flushW,
  input  logic       doNotWriteReg,
  input  logic       condEx,
  input  instrHiT    instrD,
  input  logic       aluSrcD,
  input  logic       memtoRegD,
  input  logic       regWriteD,
  input  logic       memWriteD,
  input  logic       branchD,
  input  logic [3:0] aluControlD,
  input  logic [1:0] flagWriteD,
  input  logic       pcSrcD,
  input  logic       rSelD,
  input  logic       rsrSelD,
  output logic [3:0] condE,
  output logic [1:0] flagWriteE,
  output logic       aluSrcE,
  output logic [3:0] aluControlE,
  output logic       rSelE,
  output logic       rsrSelE,
  output logic       memtoRegE,
  output logic       branchTakenE,
  output logic       regWriteM,
  output logic       memWriteM,
  output logic       memtoRegM,
  output logic       pcWrPendingF,
  output logic       regWriteW,
  output logic       memtoRegW,
  output logic       pcSrcW
);

  logic branchE;
  logic memWriteE;
  logic regWriteE;
  logic pcSrcE;
  logic pcSrcM;
  logic regWriteGatedE;
  logic memWriteGatedE;
  logic pcSrcGatedE;

  // D/E bits with side effects, cleared on flush
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      flagWriteE <= 2'b00;
      branchE    <= 1'b0;
      memWriteE  <= 1'b0;
      regWriteE  <= 1'b0;
      pcSrcE     <= 1'b0;
      memtoRegE  <= 1'b0;
    end else if (!stallE) begin
      flagWriteE <= flagWriteD;
      branchE    <= branchD;
      memWriteE  <= memWriteD;
      regWriteE  <= regWriteD;
      pcSrcE     <= pcSrcD;
      memtoRegE  <= memtoRegD;
    end
  end

  // D/E operand and condition bits
  always_ff @(posedge clk) begin
    if (!rstN) begin
      condE       <= 4'h0;
      aluSrcE     <= 1'b0;
      aluControlE <= 4'h0;
      rSelE       <= 1'b0;
      rsrSelE     <= 1'b0;
    end else if (!stallE) begin
      condE       <= instrD.dp.cond;
      aluSrcE     <= aluSrcD;
      aluControlE <= aluControlD;
      rSelE       <= rSelD;
      rsrSelE     <= rsrSelD;
    end
  end

  // Writes and branches only happen when the condition passes
  assign branchTakenE   = branchE & condEx;
  assign memWriteGatedE = memWriteE & condEx;
  assign pcSrcGatedE    = pcSrcE & condEx;
  assign regWriteGatedE = regWriteE & condEx & ~doNotWriteReg;  // Compares write no register

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
    end else if (!stallM) begin
      memWriteM <= memWriteGatedE;
      memtoRegM <= memtoRegE;
      regWriteM <= regWriteGatedE;
      pcSrcM    <= pcSrcGatedE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      memtoRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else if (!stallW) begin
      memtoRegW <= memtoRegM;
      regWriteW <= regWriteM;
      pcSrcW    <= pcSrcM;
    end
  end

  // A PC write is in flight ahead of Fetch
  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;

endmodule

// File: hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit import armCtrlPkg::*; (
  input  logic       match1EM,
  input  logic       match1EW,
  input  logic       match2EM,
  input  logic       match2EW,
  input  logic       match12DE,
  input  logic       regWriteM,
  input  logic       regWriteW,
  input  logic       memtoRegE,
  input  logic       pcWrPendingF,
  input  logic       pcSrcW,
  input  logic       branchTakenE,
  input  logic       memReady,
  output logic [1:0] forwardAE,
  output logic [1:0] forwardBE,
  output logic       stallF,
  output logic       stallD,
  output logic       flushD,
  output logic       flushE,
  output logic       stallE,
  output logic       stallM,
  output logic       stallW
);

  logic ldrStall;
  logic memWait;

  // Memory stage result is newer than Writeback
  always_comb begin
    if (match1EM && regWriteM) begin
      forwardAE = FWD_M;
    end else if (match1EW && regWriteW) begin
      forwardAE = FWD_W;
    end else begin
      forwardAE = FWD_NONE;
    end
  end

  always_comb begin
    if (match2EM && regWriteM) begin
      forwardBE = FWD_M;
    end else if (match2EW && regWriteW) begin
      forwardBE = FWD_W;
    end else begin
      forwardBE = FWD_NONE;
    end
  end

  assign memWait  = ~memReady;
  assign ldrStall = match12DE & memtoRegE;  // Load result not ready until W

  assign stallF = ldrStall | pcWrPendingF | memWait;
  assign stallD = ldrStall | memWait;

  // Flushes wait until memory is ready so no bubble is lost
  assign flushD = (pcWrPendingF | pcSrcW | branchTakenE) & ~memWait;
  assign flushE = (ldrStall | branchTakenE) & ~memWait;

  // Whole back end freezes on a memory wait
  assign stallE = memWait;
  assign stallM = memWait;
  assign stallW = memWait;

endmodule

// File: ctrlTop.sv
`timescale 1ns/100ps

module ctrlTop import armCtrlPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  instrHiT    instrD,
  input  logic       shiftRegD,
  input  logic [3:0] aluFlagsE,
  input  logic       doNotWriteReg,
  input  logic       match1EM,
  input  logic       match1EW,
  input  logic       match2EM,
  input  logic       match2EW,
  input  logic       match12DE,
  input  logic       memReady,
  output logic [1:0] regSrcD,
  output logic [1:0] immSrcD,
  output logic       aluSrcE,
  output logic [3:0] aluControlE,
  output logic       rSelE,
  output logic       rsrSelE,
  output logic       branchTakenE,
  output logic       memWriteM,
  output logic       memtoRegW,
  output logic       regWriteW,
  output logic       pcSrcW,
  output logic [1:0] prevCV,
  output logic [1:0] forwardAE,
  output logic [1:0] forwardBE,
  output logic       stallF,
  output logic       stallD,
  output logic       flushD
);

  logic       aluSrcD, memtoRegD, regWriteD, memWriteD, branchD;
  logic [3:0] aluControlD;
  logic [1:0] flagWriteD;
  logic       pcSrcD, rSelD, rsrSelD;
  logic [3:0] condE;
  logic [1:0] flagWriteE;
  logic       condEx;
  logic       memtoRegE, regWriteM, pcWrPendingF;
  logic       flushE, stallE, stallM, stallW;

  ctrlDecoder uDecoder (
    .instrD      (instrD),
    .shiftRegD   (shiftRegD),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .aluSrcD     (aluSrcD),
    .memtoRegD   (memtoRegD),
    .regWriteD   (regWriteD),
    .memWriteD   (memWriteD),
    .branchD     (branchD),
    .aluControlD (aluControlD),
    .flagWriteD  (flagWriteD),
    .pcSrcD      (pcSrcD),
    .rSelD       (rSelD),
    .rsrSelD     (rsrSelD)
  );

  ctrlPipe uPipe (
    .clk           (clk),
    .rstN          (rstN),
    .stallE        (stallE),
    .stallM        (stallM),
    .stallW        (stallW),
    .flushE        (flushE),
    .flushW        (1'b0),  // Writeback is never flushed
    .doNotWriteReg (doNotWriteReg),
    .condEx        (condEx),
    .instrD        (instrD),
    .aluSrcD       (aluSrcD),
    .memtoRegD     (memtoRegD),
    .regWriteD     (regWriteD),
    .memWriteD     (memWriteD),
    .branchD       (branchD),
    .aluControlD   (aluControlD),
    .flagWriteD    (flagWriteD),
    .pcSrcD        (pcSrcD),
    .rSelD         (rSelD),
    .rsrSelD       (rsrSelD),
    .condE         (condE),
    .flagWriteE    (flagWriteE),
    .aluSrcE       (aluSrcE),
    .aluControlE   (aluControlE),
    .rSelE         (rSelE),
    .rsrSelE       (rsrSelE),
    .memtoRegE     (memtoRegE),
    .branchTakenE  (branchTakenE),
    .regWriteM     (regWriteM),
    .memWriteM     (memWriteM),
    .memtoRegM     (),      // Only feeds the M/W register
    .pcWrPendingF  (pcWrPendingF),
    .regWriteW     (regWriteW),
    .memtoRegW     (memtoRegW),
    .pcSrcW        (pcSrcW)
  );

  condUnit uCond (
    .clk        (clk),
    .rstN       (rstN),
    .stallE     (stallE),
    .condE      (condE),
    .aluFlagsE  (aluFlagsE),
    .flagWriteE (flagWriteE),
    .condEx     (condEx),
    .prevCV     (prevCV)
  );

  hazardUnit uHazard (
    .match1EM     (match1EM),
    .match1EW     (match1EW),
    .match2EM     (match2EM),
    .match2EW     (match2EW),
    .match12DE    (match12DE),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .memtoRegE    (memtoRegE),
    .pcWrPendingF (pcWrPendingF),
    .pcSrcW       (pcSrcW),
    .branchTakenE (branchTakenE),
    .memReady     (memReady),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .flushE       (flushE),
    .stallE       (stallE),
    .stallM       (stallM),
    .stallW       (stallW)
  );

endmodule

// File: tbClockGen.sv
`timescale 1ns/100ps

module tbClockGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    rstN = 1'b0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;  // Released after three edges
  end

endmodule

// File: tbCtrlTop.sv
`timescale 1ns/100ps

module tbCtrlTop import armCtrlPkg::*; ();

  typedef struct packed {
    instrHiT    instr;
    logic [3:0] expSrc;    // {regSrcD, immSrcD}
    logic [3:0] aluFlags;
    logic [4:0] match;     // 1EM, 1EW, 2EM, 2EW, 12DE
    logic       memReady;
    logic       dnw;
    logic       shiftReg;  // Operand 2 shifted by a register amount
  } rowT;

  logic clk, rstN, shiftRegD, doNotWriteReg, memReady;
  logic match1EM, match1EW, match2EM, match2EW, match12DE;
  instrHiT instrD;
  logic [3:0] aluFlagsE, aluControlE;
  logic [1:0] regSrcD, immSrcD, prevCV, forwardAE, forwardBE;
  logic aluSrcE, rSelE, rsrSelE, branchTakenE, memWriteM, memtoRegW, regWriteW, pcSrcW;
  logic stallF, stallD, flushD;

  rowT    rows[$];
  integer seed;
  int     cycleCount = 0;
  int     cycleLimit = 0;

  // Expected pipeline state
  logic [3:0] mFlags, mCondE, mAluCtlE;
  logic [1:0] mFlagWrE;
  logic mBranchE, mMemWrE, mRegWrE, mPcSrcE, mMemtoRegE;
  logic mAluSrcE, mRSelE, mRsrSelE;
  logic mRegWrM, mMemWrM, mMemtoRegM, mPcSrcM, mRegWrW, mMemtoRegW, mPcSrcW;

  tbClockGen clockGen (.clk(clk), .rstN(rstN));

  ctrlTop dut (
    .clk(clk), .rstN(rstN), .instrD(instrD), .shiftRegD(shiftRegD), .aluFlagsE(aluFlagsE),
    .doNotWriteReg(doNotWriteReg), .match1EM(match1EM), .match1EW(match1EW),
    .match2EM(match2EM), .match2EW(match2EW), .match12DE(match12DE), .memReady(memReady),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluControlE(aluControlE),
    .rSelE(rSelE), .rsrSelE(rsrSelE), .branchTakenE(branchTakenE), .memWriteM(memWriteM),
    .memtoRegW(memtoRegW), .regWriteW(regWriteW), .pcSrcW(pcSrcW), .prevCV(prevCV),
    .forwardAE(forwardAE), .forwardBE(forwardBE), .stallF(stallF), .stallD(stallD),
    .flushD(flushD)
  );

  task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  function automatic instrHiT dpInstr(logic [3:0] c, logic imm, logic [3:0] cmd, logic s,
                                      logic [3:0] rd);
    instrHiT i;
    i = '0;
    i.dp.cond     = c;
    i.dp.op       = OP_DP;
    i.dp.immFlag  = imm;
    i.dp.cmd      = cmd;
    i.dp.setFlags = s;
    i.dp.rd       = rd;
    return i;
  endfunction

  function automatic instrHiT memInstr(logic [3:0] c, logic load, logic [3:0] rd);
    instrHiT i;
    i = '0;
    i.mem.cond = c;
    i.mem.op   = OP_MEM;
    i.mem.up   = 1'b1;
    i.mem.load = load;
    i.mem.rd   = rd;
    return i;
  endfunction

  function automatic instrHiT brInstr(logic [3:0] c);
    instrHiT i;
    i = '0;
    i.dp.cond = c;
    i.dp.op   = OP_BR;
    return i;
  endfunction

  // Control word {regWrite, memWrite, memtoReg, branch, flagWrite, aluControl, pcSrc}
  function automatic logic [10:0] ctrlOf(instrHiT i);
    logic rw, mw, m2r, br, pc;
    logic [1:0] fw;
    logic [3:0] alu;
    rw  = (i.dp.op == OP_DP) || (i.dp.op == OP_MEM && i.mem.load);
    mw  = (i.dp.op == OP_MEM) && !i.mem.load;
    m2r = (i.dp.op == OP_MEM) && i.mem.load;
    br  = (i.dp.op == OP_BR);
    alu = (i.dp.op == OP_DP) ? i.dp.cmd : CMD_ADD;
    fw  = 2'b00;
    if (i.dp.op == OP_DP) begin
      fw = {i.dp.setFlags, i.dp.setFlags && (i.dp.cmd inside
            {CMD_ADD, CMD_SUB, CMD_RSB, CMD_ADC, CMD_SBC, CMD_RSC, CMD_CMP, CMD_CMN})};
    end
    pc = (rw && i.dp.rd == PC_REG) || br;
    return {rw, mw, m2r, br, fw, alu, pc};
  endfunction

  function automatic logic condPass(logic [3:0] c, logic [3:0] f);
    logic n, z, cy, v, res;
    {n, z, cy, v} = f;
    case (c)
      4'h0: res = z;
      4'h1: res = !z;
      4'h2: res = cy;
      4'h3: res = !cy;
      4'h4: res = n;
      4'h5: res = !n;
      4'h6: res = v;
      4'h7: res = !v;
      4'h8: res = cy && !z;
      4'h9: res = !cy || z;
      4'hA: res = (n == v);
      4'hB: res = (n != v);
      4'hC: res = !z && (n == v);
      4'hD: res = z || (n != v);
      4'hE: res = 1'b1;
      default: res = 1'b0;
    endcase
    return res;
  endfunction

  task automatic addRow(input instrHiT instr, input logic [3:0] expSrc, input logic [3:0] fl,
                        input logic [4:0] mt, input logic rdy, input logic dnw);
    rowT row;
    row = {instr, expSrc, fl, mt, rdy, dnw, 1'b0};
    row.shiftReg = rows.size() % 2 == 1;  // Alternates from row to row
    rows.push_back(row);
  endtask

  task automatic addNop(input logic rdy);
    addRow(dpInstr(4'hF, 1'b1, CMD_ADD, 1'b0, 4'd0), 4'b0000, 4'h0, 5'h0, rdy, 1'b0);
  endtask

  task automatic buildTable();
    logic [31:0] r;
    addRow(dpInstr(COND_AL, 1'b1, CMD_ADD, 1'b0, 4'd1), 4'b0000, 4'h0, 5'h0, 1'b1, 1'b0);
    addRow(dpInstr(COND_AL, 1'b0, CMD_SUB, 1'b0, 4'd2), 4'b0000, 4'h0, 5'h0, 1'b1, 1'b0);
    addRow(memInstr(COND_AL, 1'b1, 4'd3), 4'b0001, 4'h0, 5'h0, 1'b1, 1'b0);
    addRow(memInstr(COND_AL, 1'b0, 4'd4), 4'b1001, 4'h0, 5'h0, 1'b1, 1'b0);
    addRow(brInstr(COND_AL), 4'b0110, 4'h0, 5'h0, 1'b1, 1'b0);
    addNop(1'b1);
    addNop(1'b1);
    for (int k = 0; k < 2; k++) begin
      addRow(dpInstr(COND_AL, 1'b0, CMD_CMP, 1'b1, 4'd0), 4'b0000, 4'h0, 5'h0, 1'b1, 1'b0);
      addRow(dpInstr(4'hF, 1'b1, CMD_ADD, 1'b0, 4'd0), 4'b0000,
             (k == 1) ? 4'b1001 : 4'b0110, 5'h0, 1'b1, 1'b1);  // Flags for the CMP in E
      for (int c = 0; c < 16; c++) begin
        addRow(memInstr(4'(c), 1'b0, 4'd5), 4'b1001, 4'h0, 5'h0, 1'b1, 1'b0);
        addRow(brInstr(4'(c)), 4'b0110, 4'h0, 5'h0, 1'b1, 1'b0);
        addNop(1'b1);
      end
    end
    addRow(dpInstr(COND_AL, 1'b1, CMD_ADD, 1'b0, 4'd1), 4'b0000, 4'h0, 5'h0, 1'b1, 1'b0);
    addRow(dpInstr(COND_AL, 1'b1, CMD_ADD, 1'b0, 4'd2), 4'b0000, 4'h0, 5'h0, 1'b1, 1'b1);
    addRow(memInstr(COND_AL, 1'b1, 4'd3), 4'b0001, 4'h0, 5'h0, 1'b1, 1'b0);
    addRow(dpInstr(COND_EQ, 1'b1, CMD_ADD, 1'b0, 4'd4), 4'b0000, 4'h0, 5'h0, 1'b1, 1'b0);
    addRow(dpInstr(COND_AL, 1'b1, CMD_ADD, 1'b0, PC_REG), 4'b0000, 4'h0, 5'h0, 1'b1, 1'b0);
    repeat (3) addNop(1'b1);
    for (int n = 0; n < 12; n++) begin
      r = $random(seed);  // Random strobes and ALU flags
      case (n % 3)
        0: addRow(dpInstr(COND_AL, 1'b0, CMD_ADD, 1'b0, 4'd7), 4'b0000, r[3:0], r[8:4],
                  1'b1, 1'b0);
        1: addRow(memInstr(COND_AL, 1'b1, 4'd6), 4'b0001, r[3:0], r[8:4], 1'b1, 1'b0);
        default: addRow(memInstr(COND_AL, 1'b0, 4'd6), 4'b1001, r[3:0], r[8:4], 1'b1, 1'b0);
      endcase
    end
    addRow(memInstr(COND_AL, 1'b1, 4'd4), 4'b0001, 4'h0, 5'h0, 1'b1, 1'b0);
    addRow(dpInstr(COND_AL, 1'b0, CMD_ADD, 1'b0, 4'd5), 4'b0000, 4'h0, 5'b00001, 1'b1, 1'b0);
    addRow(dpInstr(COND_AL, 1'b1, CMD_ADD, 1'b0, 4'd8), 4'b0000, 4'h0, 5'h0, 1'b1, 1'b0);
    addNop(1'b0);
    addNop(1'b0);
    addNop(1'b1);
    addRow(brInstr(COND_AL), 4'b0110, 4'h0, 5'h0, 1'b1, 1'b0);
    addNop(1'b0);  // Branch in E while memory waits
    addNop(1'b0);
    repeat (4) addNop(1'b1);
  endtask

  // Compare outputs with the expected state, then advance it by one edge
  task automatic checkAndStep(input rowT r);
    logic [10:0] dc;
    logic ce, bt, ldr, pend, waitM, flushE, regDp;
    logic [1:0] fa, fb;
    dc    = ctrlOf(r.instr);
    ce    = condPass(mCondE, mFlags);
    bt    = mBranchE && ce;
    waitM = !r.memReady;
    ldr   = r.match[0] && mMemtoRegE;
    pend  = dc[0] || mPcSrcE || mPcSrcM;
    regDp = (r.instr.dp.op == OP_DP) && !r.instr.dp.immFlag;
    fa = (r.match[4] && mRegWrM) ? FWD_M : ((r.match[3] && mRegWrW) ? FWD_W : FWD_NONE);
    fb = (r.match[2] && mRegWrM) ? FWD_M : ((r.match[1] && mRegWrW) ? FWD_W : FWD_NONE);
    checkVal(32'({regSrcD, immSrcD}), 32'(r.expSrc), "regSrcD/immSrcD");
    checkVal(32'(aluControlE), 32'(mAluCtlE), "aluControlE");
    checkVal(32'({aluSrcE, rSelE, rsrSelE}), 32'({mAluSrcE, mRSelE, mRsrSelE}),
             "aluSrcE/rSelE/rsrSelE");
    checkVal(32'(branchTakenE), 32'(bt), "branchTakenE");
    checkVal(32'(memWriteM), 32'(mMemWrM), "memWriteM");
    checkVal(32'({regWriteW, memtoRegW, pcSrcW}), 32'({mRegWrW, mMemtoRegW, mPcSrcW}),
             "regWriteW/memtoRegW/pcSrcW");
    checkVal(32'(prevCV), 32'(mFlags[1:0]), "prevCV");
    checkVal(32'({forwardAE, forwardBE}), 32'({fa, fb}), "forwardAE/forwardBE");
    checkVal(32'({stallF, stallD}), 32'({ldr || pend || waitM, ldr || waitM}), "stallF/stallD");
    checkVal(32'(flushD), 32'((pend || mPcSrcW || bt) && !waitM), "flushD");
    if (!waitM) begin  // Every stage holds during a memory wait
      flushE = ldr || bt;
      if (mFlagWrE[1] && ce) mFlags[3:2] = r.aluFlags[3:2];
      if (mFlagWrE[0] && ce) mFlags[1:0] = r.aluFlags[1:0];
      {mRegWrW, mMemtoRegW, mPcSrcW} = {mRegWrM, mMemtoRegM, mPcSrcM};
      mRegWrM    = mRegWrE && ce && !r.dnw;
      mMemWrM    = mMemWrE && ce;
      mMemtoRegM = mMemtoRegE;
      mPcSrcM    = mPcSrcE && ce;
      mCondE     = r.instr.dp.cond;
      mAluCtlE   = dc[4:1];
      mAluSrcE   = !regDp;  // Only register DP takes operand 2 from a register
      mRSelE     = regDp && !r.shiftReg;
      mRsrSelE   = regDp && r.shiftReg;
      {mRegWrE, mMemWrE, mMemtoRegE, mBranchE, mFlagWrE} = flushE ? 6'b0 : dc[10:5];
      mPcSrcE    = flushE ? 1'b0 : dc[0];
    end
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the table did not finish within %0d cycles", cycleLimit);
      $display("Regression failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  initial begin
    rowT idle;
    idle = '0;
    idle.memReady = 1'b1;
    instrD = '0;
    shiftRegD = 1'b0;
    aluFlagsE = 4'h0;
    doNotWriteReg = 1'b0;
    {match1EM, match1EW, match2EM, match2EW, match12DE} = 5'h0;
    memReady = 1'b1;
    {mFlags, mCondE, mAluCtlE, mFlagWrE} = '0;
    {mBranchE, mMemWrE, mRegWrE, mPcSrcE, mMemtoRegE} = '0;
    {mAluSrcE, mRSelE, mRsrSelE} = '0;
    {mRegWrM, mMemWrM, mMemtoRegM, mPcSrcM, mRegWrW, mMemtoRegW, mPcSrcW} = '0;
    seed = 32'he099;
    buildTable();
    cycleLimit = rows.size() + 20;
    wait (rstN);
    @(negedge clk);
    checkAndStep(idle);  // All zero straight out of reset
    foreach (rows[i]) begin
      @(posedge clk);
      instrD        <= rows[i].instr;
      shiftRegD     <= rows[i].shiftReg;
      aluFlagsE     <= rows[i].aluFlags;
      {match1EM, match1EW, match2EM, match2EW, match12DE} <= rows[i].match;
      memReady      <= rows[i].memReady;
      doNotWriteReg <= rows[i].dnw;
      @(negedge clk);
      checkAndStep(rows[i]);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

// File: build.f
armCtrlPkg.sv
ctrlDecoder.sv
condUnit.sv
ctrlPipe.sv
hazardUnit.sv
ctrlTop.sv
tbClockGen.sv
tbCtrlTop.sv

// File: runSim.sh
#!/usr/bin/env bash
# Compile the control path with its testbench and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -f build.f --top-module tbCtrlTop \
  -o simCtrlTop \
  && ./obj_dir/simCtrlTop \
  || { echo "Simulation ended with an error status"; exit 1; }
